// ==== all.f ====
+incdir+.
i4_pixel_pkg.sv
i4_rd_pkg.sv
intra4_predict.sv
mode_rd_score.sv
best_mode_select.sv
neighbor_context.sv
pick_best_intra4.sv
pick_best_intra4_assert.sv
tb_pick_best_intra4.sv

// ==== best_mode_select.sv ====
// Lowest-score mode choice among the four candidates
// Two-level comparator tree, lower mode wins a tie

`timescale 1ns/1ns
`include "i4_defines.svh"

module best_mode_select (
    input  i4_rd_pkg::score_t [`I4_MODES-1:0] score_i,
    output i4_rd_pkg::mode_t                  mode_o
);
    import i4_rd_pkg::*;

    mode_t  lo_mode;
    mode_t  hi_mode;
    score_t lo_score;
    score_t hi_score;

    always_comb begin
        // DC against TM, VE against HE
        lo_mode  = (score_i[MODE_TM] < score_i[MODE_DC]) ? MODE_TM : MODE_DC;
        hi_mode  = (score_i[MODE_HE] < score_i[MODE_VE]) ? MODE_HE : MODE_VE;
        lo_score = score_i[lo_mode];
        hi_score = score_i[hi_mode];

        // Upper pair must be strictly better
        mode_o   = (hi_score < lo_score) ? hi_mode : lo_mode;
    end

endmodule

// ==== i4_defines.svh ====
// Global sizes for the intra 4x4 luma mode decision
// Block and mode counts, SSE and score widths, frame bias

`ifndef I4_DEFINES_SVH
`define I4_DEFINES_SVH

// Sub-blocks per macroblock and candidate modes
`define I4_BLOCKS      16
`define I4_MODES       4

// 16 * 255^2 fits in 20 bits
`define I4_SSE_W       20
`define I4_SCORE_W     64

// Multiplied by lambda to seed the macroblock total
`define I4_FRAME_BIAS  211

`endif

// ==== i4_pixel_pkg.sv ====
// Pixel-level types for the intra 4x4 luma path
// Samples, 4x4 blocks, neighbor sets, 16x16 macroblock
// Raster position helper shared by the store and the source fetch

package i4_pixel_pkg;

    typedef logic [7:0] pix_t;

    // Indexed [y][x], row 0 in the low bytes
    typedef pix_t [3:0][3:0] blk4_t;

    typedef struct packed {
        pix_t       top_left;
        pix_t [3:0] top;
        pix_t       top_right;
        pix_t [3:0] left;
    } nbr_t;

    // Raster order, entry row * 16 + column
    typedef pix_t [255:0] mb_t;

    // Pixel (y, x) of sub-block idx in raster order
    // y or x of -1 and 4 reach into the neighboring blocks
    function automatic int pix_pos(input logic [3:0] idx, input int y, input int x);
        return (int'(idx[3:2]) * 4 + y) * 16 + int'(idx[1:0]) * 4 + x;
    endfunction

endpackage

// ==== i4_rd_pkg.sv ====
// Rate-distortion types for the intra 4x4 mode decision
// Mode encoding, SSE and score words, per-macroblock mode map
// Fixed header cost of each mode

`include "i4_defines.svh"

package i4_rd_pkg;

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } mode_t;

    typedef logic [`I4_SSE_W-1:0]   sse_t;
    typedef logic [`I4_SCORE_W-1:0] score_t;

    // Entry i holds the mode of sub-block i
    typedef mode_t [`I4_BLOCKS-1:0] mb_modes_t;

    // Mode signalling cost, indexed by mode_t
    localparam logic [`I4_MODES-1:0][15:0] MODE_COST = {
        16'd1874,
        16'd1723,
        16'd1151,
        16'd40
    };

endpackage

// ==== intra4_predict.sv ====
// Combinational 4x4 luma predictors
// DC, TM, VE and HE built from one neighbor set

`timescale 1ns/1ns
`include "i4_defines.svh"

module intra4_predict (
    input  i4_pixel_pkg::nbr_t                  nbr_i,
    output i4_pixel_pkg::blk4_t [`I4_MODES-1:0] pred_o
);
    import i4_pixel_pkg::*;
    import i4_rd_pkg::*;

    // (a + 2b + c + 2) >> 2
    function automatic pix_t avg3(input pix_t a, input pix_t b, input pix_t c);
        logic [9:0] s;
        s = 10'(a) + {1'b0, b, 1'b0} + 10'(c) + 10'd2;
        return s[9:2];
    endfunction

    logic [10:0]       dc_sum;
    logic signed [9:0] tm_val;
    pix_t [5:0]        top_ext;
    pix_t [3:0]        ve_row;
    pix_t [3:0]        he_col;

    // top_left, top[0..3], top_right
    assign top_ext = {nbr_i.top_right, nbr_i.top, nbr_i.top_left};

    always_comb begin
        dc_sum = 11'd4;
        for (int k = 0; k < 4; k++) begin
            dc_sum = dc_sum + 11'(nbr_i.top[k]) + 11'(nbr_i.left[k]);
        end
    end

    // ------------------------------
    // Smoothed edges for VE and HE
    always_comb begin
        for (int x = 0; x < 4; x++) begin
            ve_row[x] = avg3(top_ext[x], top_ext[x+1], top_ext[x+2]);
        end
        he_col[0] = avg3(nbr_i.top_left, nbr_i.left[0], nbr_i.left[1]);
        he_col[1] = avg3(nbr_i.left[0], nbr_i.left[1], nbr_i.left[2]);
        he_col[2] = avg3(nbr_i.left[1], nbr_i.left[2], nbr_i.left[3]);
        he_col[3] = avg3(nbr_i.left[2], nbr_i.left[3], nbr_i.left[3]);
    end

    // ------------------------------
    // Fill the four blocks
    always_comb begin
        tm_val = '0;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                pred_o[MODE_DC][y][x] = dc_sum[10:3];

                // Gradient, clipped to 0..255
                tm_val = 10'(nbr_i.top[x]) + 10'(nbr_i.left[y]) - 10'(nbr_i.top_left);
                if (tm_val < 0) begin
                    pred_o[MODE_TM][y][x] = 8'd0;
                end else if (tm_val > 10'sd255) begin
                    pred_o[MODE_TM][y][x] = 8'd255;
                end else begin
                    pred_o[MODE_TM][y][x] = tm_val[7:0];
                end

                pred_o[MODE_VE][y][x] = ve_row[x];
                pred_o[MODE_HE][y][x] = he_col[y];
            end
        end
    end

endmodule

// ==== mode_rd_score.sv ====
// Rate-distortion score of one 4x4 prediction
// Registered SSE and SSE * 256 + mode cost * lambda

`timescale 1ns/1ns

module mode_rd_score #(
    parameter i4_rd_pkg::mode_t MODE = i4_rd_pkg::MODE_DC
) (
    input  logic                clk,
    input  logic                rst_n,
    input  i4_pixel_pkg::blk4_t pred_i,
    input  i4_pixel_pkg::blk4_t src_i,
    input  logic [31:0]         lambda_i,
    output i4_rd_pkg::sse_t     sse_o,
    output i4_rd_pkg::score_t   score_o
);
    import i4_rd_pkg::*;

    sse_t              sse_sum;
    logic signed [8:0] diff;
    logic [15:0]       sq;

    // Sum of squared differences over the block
    always_comb begin
        sse_sum = '0;
        diff    = '0;
        sq      = '0;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                diff    = $signed({1'b0, pred_i[y][x]}) - $signed({1'b0, src_i[y][x]});
                sq      = diff * diff;
                sse_sum = sse_sum + sse_t'(sq);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sse_o   <= '0;
            score_o <= '0;
        end else begin
            sse_o   <= sse_sum;
            score_o <= (score_t'(sse_sum) << 8)
                     + score_t'(MODE_COST[MODE]) * score_t'(lambda_i);
        end
    end

endmodule

// ==== neighbor_context.sv ====
// Reconstructed macroblock store
// Block write-back and neighbor extraction for the current sub-block

`timescale 1ns/1ns

module neighbor_context (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [3:0]                blk_idx_i,
    input  logic                      store_i,
    input  i4_pixel_pkg::blk4_t       blk_i,
    input  i4_pixel_pkg::pix_t [15:0] top_i,
    input  i4_pixel_pkg::pix_t        top_right_i,
    input  i4_pixel_pkg::pix_t [15:0] left_i,
    input  i4_pixel_pkg::pix_t        top_left_i,
    output i4_pixel_pkg::nbr_t        nbr_o,
    output i4_pixel_pkg::mb_t         recon_o
);
    import i4_pixel_pkg::*;

    mb_t recon;

    // ------------------------------
    // Write-back of the chosen block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recon <= '0;
        end else if (store_i) begin
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    recon[pix_pos(blk_idx_i, y, x)] <= blk_i[y][x];
                end
            end
        end
    end

    assign recon_o = recon;

    // ------------------------------
    // Neighbors of the current block
    always_comb begin
        int px;
        int py;
        px = 4 * int'(blk_idx_i[1:0]);
        py = 4 * int'(blk_idx_i[3:2]);

        for (int k = 0; k < 4; k++) begin
            if (py == 0) begin
                nbr_o.top[k] = top_i[px + k];
            end else begin
                nbr_o.top[k] = recon[pix_pos(blk_idx_i, -1, k)];
            end
            if (px == 0) begin
                nbr_o.left[k] = left_i[py + k];
            end else begin
                nbr_o.left[k] = recon[pix_pos(blk_idx_i, k, -1)];
            end
        end

        if (px == 0 && py == 0) begin
            nbr_o.top_left = top_left_i;
        end else if (py == 0) begin
            nbr_o.top_left = top_i[px - 1];
        end else if (px == 0) begin
            nbr_o.top_left = left_i[py - 1];
        end else begin
            nbr_o.top_left = recon[pix_pos(blk_idx_i, -1, -1)];
        end

        // Rightmost column always borrows the macroblock top-right
        if (px == 12) begin
            nbr_o.top_right = top_right_i;
        end else if (py != 0) begin
            nbr_o.top_right = recon[pix_pos(blk_idx_i, -1, 4)];
        end else begin
            nbr_o.top_right = top_i[px + 4];
        end
    end

endmodule

// ==== pick_best_intra4.sv ====
// Intra 4x4 luma mode decision for one macroblock
// Control FSM, block counter, source block fetch
// Per-block scoring, mode choice and total score accumulation

`timescale 1ns/1ns
`include "i4_defines.svh"

module pick_best_intra4 (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  logic [31:0]               lambda_i,
    input  i4_pixel_pkg::mb_t         ysrc_i,
    input  i4_pixel_pkg::pix_t [15:0] top_i,
    input  i4_pixel_pkg::pix_t        top_right_i,
    input  i4_pixel_pkg::pix_t [15:0] left_i,
    input  i4_pixel_pkg::pix_t        top_left_i,
    output i4_pixel_pkg::mb_t         yout_o,
    output i4_rd_pkg::mb_modes_t      modes_o,
    output i4_rd_pkg::score_t         score_o,
    output logic                      done_o
);
    import i4_pixel_pkg::*;
    import i4_rd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SCORE,
        STORE,
        DONE
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    logic [3:0]             blk_idx;
    logic                   store;
    blk4_t                  src_blk;
    nbr_t                   nbr;
    blk4_t [`I4_MODES-1:0]  pred;
    score_t [`I4_MODES-1:0] mode_score;
    mode_t                  best_mode;
    mb_modes_t              modes;
    score_t                 total;

    // ------------------------------
    // Control FSM
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start_i) state_nxt = SCORE;
            SCORE:   state_nxt = STORE;
            STORE:   state_nxt = (blk_idx == 4'd15) ? DONE : SCORE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign store  = (state == STORE);
    assign done_o = (state == DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            blk_idx <= '0;
            total   <= '0;
            for (int k = 0; k < `I4_BLOCKS; k++) begin
                modes[k] <= MODE_DC;
            end
        end else begin
            state <= state_nxt;
            if (state == IDLE && start_i) begin
                blk_idx <= '0;
                total   <= score_t'(`I4_FRAME_BIAS) * score_t'(lambda_i);
            end else if (store) begin
                blk_idx        <= blk_idx + 4'd1;
                total          <= total + mode_score[best_mode];
                modes[blk_idx] <= best_mode;
            end
        end
    end

    // Current source block
    always_comb begin
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                src_blk[y][x] = ysrc_i[pix_pos(blk_idx, y, x)];
            end
        end
    end

    // ------------------------------
    // Datapath
    neighbor_context u_nbr (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_idx_i   (blk_idx),
        .store_i     (store),
        .blk_i       (pred[best_mode]),
        .top_i       (top_i),
        .top_right_i (top_right_i),
        .left_i      (left_i),
        .top_left_i  (top_left_i),
        .nbr_o       (nbr),
        .recon_o     (yout_o)
    );

    intra4_predict u_pred (
        .nbr_i  (nbr),
        .pred_o (pred)
    );

    for (genvar m = 0; m < `I4_MODES; m++) begin : g_score
        mode_rd_score #(
            .MODE (mode_t'(m))
        ) u_score (
            .clk      (clk),
            .rst_n    (rst_n),
            .pred_i   (pred[m]),
            .src_i    (src_blk),
            .lambda_i (lambda_i),
            .sse_o    (),
            .score_o  (mode_score[m])
        );
    end

    best_mode_select u_best (
        .score_i (mode_score),
        .mode_o  (best_mode)
    );

    assign modes_o = modes;
    assign score_o = total;

endmodule

// ==== pick_best_intra4_assert.sv ====
// Protocol assertions for the intra 4x4 mode decision top level
// done_o timing after an accepted start, single-cycle done pulse

`timescale 1ns/1ns

module pick_best_intra4_assert (
    input logic clk,
    input logic rst_n,
    input logic start_i,
    input logic done_o
);
    // Edges since the accepted start, 0 while idle
    logic [5:0] since_start;
    int         fails = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_start <= '0;
        end else if (since_start == 6'd33) begin
            since_start <= '0;
        end else if (since_start != 6'd0 || start_i) begin
            since_start <= since_start + 6'd1;
        end
    end

    done_timing: assert property (
        @(posedge clk) disable iff (!rst_n) done_o |-> since_start == 6'd33
    ) else begin
        fails++;
        $error("done_o high outside the 33rd cycle after an accepted start");
    end

    done_expected: assert property (
        @(posedge clk) disable iff (!rst_n) since_start == 6'd33 |-> done_o
    ) else begin
        fails++;
        $error("done_o missing 33 cycles after an accepted start");
    end

    done_single: assert property (
        @(posedge clk) disable iff (!rst_n) done_o |=> !done_o
    ) else begin
        fails++;
        $error("done_o held for more than one cycle");
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the intra 4x4 mode decision testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_pick_best_intra4 -o sim_tb

output="$(./obj_dir/sim_tb +verilator+error+limit+100 2>&1)" || true
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== tb_pick_best_intra4.sv ====
// Testbench for the intra 4x4 luma mode decision
// Reference model of neighbors, predictors, RD scores and the total
// Flat, random, striped and gradient macroblocks, busy start check

`timescale 1ns/1ns
`include "i4_defines.svh"

module tb_pick_best_intra4;
    import i4_pixel_pkg::*;
    import i4_rd_pkg::*;

    localparam int        DONE_TIMEOUT = 100;
    localparam int        HDR_COST [4] = '{40, 1151, 1723, 1874};
    localparam mb_modes_t ALL_DC       = mb_modes_t'(32'd0);

    logic        clk;
    logic        rst_n;
    logic        start_i;
    logic [31:0] lambda_i;
    mb_t         ysrc_i;
    pix_t [15:0] top_i;
    pix_t        top_right_i;
    pix_t [15:0] left_i;
    pix_t        top_left_i;
    mb_t         yout_o;
    mb_modes_t   modes_o;
    score_t      score_o;
    logic        done_o;

    integer    seed;
    int        errors;
    int        test_errors;
    int        tests;
    int        failed;
    string     cur_name;
    mb_t       exp_yout;
    mb_modes_t exp_modes;
    score_t    exp_score;

    pick_best_intra4 UUT (.*);

    bind pick_best_intra4 pick_best_intra4_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // Reference model
    function automatic pix_t smooth3(input pix_t a, input pix_t b, input pix_t c);
        return pix_t'((int'(a) + 2 * int'(b) + int'(c) + 2) >> 2);
    endfunction

    // Pixel at macroblock row y and column x, or the border pixel beyond it
    function automatic pix_t edge_pix(input mb_t rec, input int y, input int x);
        if (y < 0 && x < 0) return top_left_i;
        if (y < 0) return top_i[x];
        if (x < 0) return left_i[y];
        return rec[y * 16 + x];
    endfunction

    task automatic run_model();
        mb_t    rec;
        pix_t   te [6];
        pix_t   le [6];
        blk4_t  pred [4];
        score_t sc [4];
        int     px;
        int     py;
        int     dc;
        int     d;
        int     sse;
        int     best;
        rec       = '0;
        exp_score = score_t'(`I4_FRAME_BIAS) * score_t'(lambda_i);
        for (int i = 0; i < `I4_BLOCKS; i++) begin
            px = 4 * (i % 4);
            py = 4 * (i / 4);
            // Corner, four edge pixels, then the far end
            te[0] = edge_pix(rec, py - 1, px - 1);
            le[0] = te[0];
            dc    = 4;
            for (int k = 0; k < 4; k++) begin
                te[k + 1] = edge_pix(rec, py - 1, px + k);
                le[k + 1] = edge_pix(rec, py + k, px - 1);
                dc        = dc + int'(te[k + 1]) + int'(le[k + 1]);
            end
            te[5] = (px == 12) ? top_right_i : edge_pix(rec, py - 1, px + 4);
            le[5] = le[4];
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    d = int'(te[x + 1]) + int'(le[y + 1]) - int'(te[0]);
                    pred[0][y][x] = pix_t'(dc >> 3);
                    pred[1][y][x] = pix_t'((d < 0) ? 0 : ((d > 255) ? 255 : d));
                    pred[2][y][x] = smooth3(te[x], te[x + 1], te[x + 2]);
                    pred[3][y][x] = smooth3(le[y], le[y + 1], le[y + 2]);
                end
            end
            best = 0;
            for (int m = 0; m < `I4_MODES; m++) begin
                sse = 0;
                for (int y = 0; y < 4; y++) begin
                    for (int x = 0; x < 4; x++) begin
                        d   = int'(pred[m][y][x]) - int'(ysrc_i[(py + y) * 16 + px + x]);
                        sse = sse + d * d;
                    end
                end
                sc[m] = score_t'(sse) * 256 + score_t'(HDR_COST[m]) * score_t'(lambda_i);
                if (sc[m] < sc[best]) best = m;
            end
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    rec[(py + y) * 16 + px + x] = pred[best][y][x];
                end
            end
            exp_modes[i] = mode_t'(best);
            exp_score    = exp_score + sc[best];
        end
        exp_yout = rec;
    endtask

    // ------------------------------
    // Compare tasks
    task automatic check_mb(input string what, input mb_t got, input mb_t exp);
        int bad;
        int first;
        bad   = 0;
        first = -1;
        for (int k = 0; k < 256; k++) begin
            if (got[k] !== exp[k]) begin
                bad++;
                if (first < 0) first = k;
            end
        end
        if (bad != 0) begin
            $display("Error at %0t ns: %s differs in %0d pixels, first %0d got %h expected %h",
                     $time, what, bad, first, got[first], exp[first]);
            test_errors++;
        end
    endtask

    task automatic check_modes(input string what, input mb_modes_t got, input mb_modes_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_score(input string what, input score_t got, input score_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic expect_mode(input mode_t m);
        logic seen;
        seen = 1'b0;
        for (int k = 0; k < `I4_BLOCKS; k++) begin
            if (modes_o[k] == m) seen = 1'b1;
        end
        if (!seen) begin
            $display("Error at %0t ns: mode %s was never chosen in test %s",
                     $time, m.name(), cur_name);
            test_errors++;
        end
    endtask

    // ------------------------------
    // Stimulus
    task automatic fill_flat(input pix_t v);
        lambda_i    = '0;
        ysrc_i      = {256{v}};
        top_i       = {16{v}};
        left_i      = {16{v}};
        top_right_i = v;
        top_left_i  = v;
    endtask

    task automatic fill_random(input logic [31:0] lambda);
        lambda_i = lambda;
        for (int k = 0; k < 256; k++) begin
            ysrc_i[k] = pix_t'($random(seed));
        end
        for (int k = 0; k < 16; k++) begin
            top_i[k]  = pix_t'($random(seed));
            left_i[k] = pix_t'($random(seed));
        end
        top_right_i = pix_t'($random(seed));
        top_left_i  = pix_t'($random(seed));
    endtask

    // 0 vertical ramp, 1 horizontal ramp, 2 diagonal gradient
    function automatic pix_t pattern_pix(input int kind, input int y, input int x);
        case (kind)
            0:       return pix_t'(10 * x + 20);
            1:       return pix_t'(10 * y + 20);
            default: return pix_t'(8 * x + 6 * y + 20);
        endcase
    endfunction

    // Flat 200 borders across the stripes keep TM from matching
    task automatic fill_pattern(input int kind);
        lambda_i = 32'd1;
        for (int y = 0; y < 16; y++) begin
            for (int x = 0; x < 16; x++) begin
                ysrc_i[y * 16 + x] = pattern_pix(kind, y, x);
            end
        end
        for (int k = 0; k < 16; k++) begin
            top_i[k]  = (kind == 1) ? 8'd200 : pattern_pix(kind, -1, k);
            left_i[k] = (kind == 0) ? 8'd200 : pattern_pix(kind, k, -1);
        end
        top_left_i  = pattern_pix(kind, -1, -1);
        top_right_i = (kind == 1) ? 8'd200 : pattern_pix(kind, -1, 16);
    endtask

    // One start pulse, optional second pulse while busy, then compare
    task automatic run_case(input int restart_at);
        int waited;
        run_model();
        @(negedge clk);
        start_i = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            start_i = (waited == restart_at);
        end while (done_o !== 1'b1 && waited < DONE_TIMEOUT);
        if (done_o !== 1'b1) begin
            $display("Timeout: done_o did not rise within %0d cycles in test %s",
                     DONE_TIMEOUT, cur_name);
            test_errors++;
        end else begin
            check_mb("yout_o", yout_o, exp_yout);
            check_modes("modes_o", modes_o, exp_modes);
            check_score("score_o", score_o, exp_score);
        end
    endtask

    task automatic begin_test(input string name);
        cur_name    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        errors = errors + test_errors;
        if (test_errors != 0) failed++;
        $display("Test %0d (%s): %s", tests, cur_name, (test_errors == 0) ? "ok" : "mismatch");
    endtask

    // ------------------------------
    initial begin
        seed        = 32'he312;
        errors      = 0;
        tests       = 0;
        failed      = 0;
        rst_n       = 1'b0;
        start_i     = 1'b0;
        lambda_i    = '0;
        ysrc_i      = '0;
        top_i       = '0;
        top_right_i = '0;
        left_i      = '0;
        top_left_i  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        begin_test("reset state");
        if (done_o !== 1'b0) begin
            $display("Error at %0t ns: done_o is not low after reset", $time);
            test_errors++;
        end
        check_score("score_o after reset", score_o, '0);
        end_test();

        begin_test("flat macroblock, lambda 0");
        fill_flat(pix_t'($random(seed)));
        run_case(0);
        check_modes("modes_o all DC", modes_o, ALL_DC);
        check_mb("yout_o against source", yout_o, ysrc_i);
        check_score("score_o zero", score_o, '0);
        end_test();

        for (int n = 0; n < 8; n++) begin
            begin_test("random macroblock");
            fill_random($random(seed) & 32'h3ff);
            run_case(0);
            end_test();
        end

        begin_test("vertical stripes");
        fill_pattern(0);
        run_case(0);
        expect_mode(MODE_VE);
        end_test();

        begin_test("horizontal stripes");
        fill_pattern(1);
        run_case(0);
        expect_mode(MODE_HE);
        end_test();

        begin_test("gradient");
        fill_pattern(2);
        run_case(0);
        expect_mode(MODE_TM);
        end_test();

        begin_test("large lambda");
        fill_random(32'h8000_0000 | $random(seed));
        run_case(0);
        check_modes("modes_o all DC", modes_o, ALL_DC);
        end_test();

        begin_test("start pulse during a run");
        fill_random($random(seed) & 32'h3ff);
        run_case(12);
        end_test();

        if (UUT.u_assert.fails != 0) begin
            $display("%0d protocol assertion failures", UUT.u_assert.fails);
            errors = errors + UUT.u_assert.fails;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
